/* Makefile */
# Verilator build and run of the host bridge testbench.
# Any variable can be overridden, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= host_bridge_tb
FILELIST  ?= host_bridge.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Checks failed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A nonzero exit or the fail message in the log marks the run as failed
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* host_bridge.f */
src/audio_pkg.sv
src/video_pkg.sv
src/audio_compressor.sv
src/audio_mixer.sv
src/fb_config.sv
src/activity_led.sv
src/host_bridge.sv
verif/host_bridge_properties.sv
verif/host_bridge_tb.sv

/* src/activity_led.sv */
//------------------------------------------------
// Retriggerable hold timer for an activity LED.
// Each request reloads the counter, and the LED
// stays lit for HOLD_CYCLES cycles after the last.
//------------------------------------------------

`timescale 1ns/1ps

module activity_led #(
	parameter int unsigned HOLD_CYCLES = 4500000
) (
	input  logic clk_sys,
	input  logic cpu_reset,
	input  logic req,
	output logic led
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			count <= '0;
		end else if (req) begin
			count <= CNT_W'(HOLD_CYCLES);
		end else if (count != '0) begin
			count <= count - CNT_W'(1);
		end
	end

	// Lit on the edge after the request through HOLD_CYCLES edges
	assign led = (count != '0);

endmodule

/* src/audio_compressor.sv */
//------------------------------------------------
// Dynamic boost for one audio channel. Applies the
// 2x or 4x two-segment curve to the magnitude of a
// signed sample and registers the result, so the
// boosted sample appears one cycle after its input.
//------------------------------------------------

`timescale 1ns/1ps

module audio_compressor
	import audio_pkg::*;
(
	input  logic    clk_sys,
	input  logic    cpu_reset,
	input  sample_t sample_in,
	input  boost_t  boost,
	output sample_t sample_out
);

	logic    negative;
	mag_t    mag;
	mag_t    curve_2x;
	mag_t    curve_4x;
	mag_t    curve_sel;
	sample_t sample_next;

	assign negative = sample_in[15];

	// ------------------------------------------------
	// Curve evaluation on the magnitude
	// ------------------------------------------------
	always_comb begin
		mag = negative ? (~sample_in + 16'd1) : sample_in;

		// Linear gain below the knee, gentle slope above it
		if (mag < COMP_X1) begin
			curve_2x = mag * COMP_A1;
		end else begin
			curve_2x = ((mag - COMP_X1) / COMP_F1) + COMP_B1;
		end

		if (mag < COMP_X2) begin
			curve_4x = mag * COMP_A2;
		end else begin
			curve_4x = ((mag - COMP_X2) / COMP_F2) + COMP_B2;
		end

		// Anything other than 4x takes the milder curve
		curve_sel = (boost == boost_4x) ? curve_4x : curve_2x;

		// Sign goes back on by negation
		sample_next = negative ? (~curve_sel + 16'd1) : curve_sel;
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			sample_out <= '0;
		end else begin
			sample_out <= sample_next;
		end
	end

endmodule

/* src/audio_mixer.sv */
//------------------------------------------------
// Stereo output mixer. Adds the PC speaker at the
// selected volume to both sound-card channels, then
// picks the plain mix (1 cycle) or the compressed
// mix (2 cycles) depending on the boost mode.
//------------------------------------------------

`timescale 1ns/1ps

module audio_mixer
	import audio_pkg::*;
(
	input  logic     clk_sys,
	input  logic     cpu_reset,
	input  sample_t  sb_left,
	input  sample_t  sb_right,
	input  logic     speaker,
	input  spk_vol_t spk_vol,
	input  boost_t   boost,
	output sample_t  audio_left,
	output sample_t  audio_right
);

	sample_t spk_term;
	sample_t mix_left;
	sample_t mix_right;
	sample_t comp_left;
	sample_t comp_right;

	// Speaker square wave adds 2048 at step 0 up to 16384 at step 3
	assign spk_term = speaker ? sample_t'(16'd2048 << spk_vol) : '0;

	// Mix stage uses a 16-bit wrapping add
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			mix_left  <= '0;
			mix_right <= '0;
		end else begin
			mix_left  <= sb_left + spk_term;
			mix_right <= sb_right + spk_term;
		end
	end

	audio_compressor comp_left_inst (
		.clk_sys    (clk_sys),
		.cpu_reset  (cpu_reset),
		.sample_in  (mix_left),
		.boost      (boost),
		.sample_out (comp_left)
	);

	audio_compressor comp_right_inst (
		.clk_sys    (clk_sys),
		.cpu_reset  (cpu_reset),
		.sample_in  (mix_right),
		.boost      (boost),
		.sample_out (comp_right)
	);

	assign audio_left  = (boost == boost_none) ? mix_left : comp_left;
	assign audio_right = (boost == boost_none) ? mix_right : comp_right;

endmodule

/* src/audio_pkg.sv */
//------------------------------------------------
// Audio types shared by the output mixer and the
// boost compressor. Import with audio_pkg::* in the
// module header of any block that handles samples.
//------------------------------------------------

package audio_pkg;

	// Signed two's complement sample of one channel
	typedef logic signed [15:0] sample_t;

	// Unsigned magnitude of a sample inside the compressor
	typedef logic [15:0] mag_t;

	// Speaker term is 2048 shifted left by this step
	typedef logic [1:0] spk_vol_t;

	typedef enum logic [1:0] {
		boost_none = 2'd0,
		boost_2x   = 2'd1,
		boost_4x   = 2'd2
	} boost_t;

	// ------------------------------------------------
	// Compressor curves
	// ------------------------------------------------
	// Gain A below knee X, slope 1/F above it, offset B = X * A
	localparam mag_t COMP_A1 = 16'd2;
	localparam mag_t COMP_F1 = 16'd4;
	localparam mag_t COMP_X1 = 16'd14044;
	localparam mag_t COMP_B1 = 16'd28088;

	localparam mag_t COMP_A2 = 16'd4;
	localparam mag_t COMP_F2 = 16'd8;
	localparam mag_t COMP_X2 = 16'd7399;
	localparam mag_t COMP_B2 = 16'd29596;

endpackage

/* src/fb_config.sv */
//------------------------------------------------
// Builds the scan-out descriptor for the scaler's
// framebuffer reader from the VGA mode registers,
// and widens 18-bit palette writes to 24 bits.
// All outputs are registered, one cycle latency.
//------------------------------------------------

`timescale 1ns/1ps

module fb_config
	import video_pkg::*;
(
	input  logic        clk_sys,
	input  logic        cpu_reset,
	input  vga_mode_t   vga_mode,
	input  logic        vga_off,
	input  video_opts_t video_opts,
	input  pal_addr_t   pal_addr,
	input  pal18_t      pal_data,
	input  logic        pal_we,
	output fb_desc_t    fb,
	output pal_addr_t   fb_pal_addr,
	output pal24_t      fb_pal_data,
	output logic        fb_pal_we
);

	fb_desc_t   fb_next;
	pal24_t     pal_wide;
	logic [2:0] fmt_low;

	// Replicate the top bits so full scale stays full scale
	function automatic chan8_t expand_chan(input chan6_t c);
		return {c, c[5:4]};
	endfunction

	// ------------------------------------------------
	// Descriptor fields
	// ------------------------------------------------
	always_comb begin
		case (vga_mode.depth)
			depth_24bpp: fmt_low = 3'b101;
			depth_16bpp: fmt_low = 3'b100;
			default:     fmt_low = 3'b011;
		endcase

		// Text and narrow modes go through the normal VGA output
		fb_next.en   = !vga_mode.narrow && (vga_mode.depth != depth_text);
		fb_next.base = {FB_BASE_PREFIX, vga_mode.start_addr, 2'b00};

		if (vga_mode.depth == depth_24bpp) begin
			fb_next.width = 12'd640;
		end else if (vga_mode.narrow) begin
			fb_next.width = {1'b0, vga_mode.width, 2'b00};
		end else begin
			fb_next.width = {vga_mode.width, 3'b000};
		end

		fb_next.height = vga_mode.line_double ? {2'b00, vga_mode.height[10:1]}
		                                      : {1'b0, vga_mode.height};
		fb_next.stride      = {2'b00, vga_mode.stride, 3'b000};
		fb_next.format      = {~video_opts.rgb_order, ~video_opts.format_565, fmt_low};
		fb_next.force_blank = vga_off;
	end

	always_comb begin
		pal_wide.r = expand_chan(pal_data.r);
		pal_wide.g = expand_chan(pal_data.g);
		pal_wide.b = expand_chan(pal_data.b);
	end

	always_ff @(posedge clk_sys) begin
		fb          <= fb_next;
		fb_pal_addr <= pal_addr;
		fb_pal_data <= pal_wide;
		fb_pal_we   <= pal_we;
		if (cpu_reset) begin
			fb.en     <= 1'b0;
			fb_pal_we <= 1'b0;
		end
	end

endmodule

/* src/host_bridge.sv */
//------------------------------------------------
// Host-side glue around the PC core, all on clk_sys.
// Mixes speaker and sound card audio with optional
// boost, derives the framebuffer descriptor and
// palette writes, and drives the two disk LEDs.
// HOLD_CYCLES sets the LED hold time.
//------------------------------------------------

`timescale 1ns/1ps

module host_bridge
	import audio_pkg::*;
	import video_pkg::*;
#(
	parameter int unsigned HOLD_CYCLES = 4500000
) (
	input  logic        clk_sys,
	input  logic        cpu_reset,

	// Audio from the core
	input  sample_t     sb_left,
	input  sample_t     sb_right,
	input  logic        speaker,
	input  spk_vol_t    spk_vol,
	input  boost_t      boost,

	// VGA mode registers and options
	input  vga_mode_t   vga_mode,
	input  logic        vga_off,
	input  video_opts_t video_opts,

	// Palette write strobe
	input  pal_addr_t   pal_addr,
	input  pal18_t      pal_data,
	input  logic        pal_we,

	// Bits 5..0 hard disks, 7..6 floppy
	input  logic [7:0]  disk_req,

	output sample_t     audio_left,
	output sample_t     audio_right,
	output fb_desc_t    fb,
	output pal_addr_t   fb_pal_addr,
	output pal24_t      fb_pal_data,
	output logic        fb_pal_we,
	output logic        led_disk,
	output logic        led_user
);

	logic hdd_req;
	logic fdd_req;

	assign hdd_req = |disk_req[5:0];
	assign fdd_req = |disk_req[7:6];

	// ------------------------------------------------
	// Audio
	// ------------------------------------------------
	audio_mixer audio_mixer_inst (
		.clk_sys     (clk_sys),
		.cpu_reset   (cpu_reset),
		.sb_left     (sb_left),
		.sb_right    (sb_right),
		.speaker     (speaker),
		.spk_vol     (spk_vol),
		.boost       (boost),
		.audio_left  (audio_left),
		.audio_right (audio_right)
	);

	// ------------------------------------------------
	// Framebuffer
	// ------------------------------------------------
	fb_config fb_config_inst (
		.clk_sys     (clk_sys),
		.cpu_reset   (cpu_reset),
		.vga_mode    (vga_mode),
		.vga_off     (vga_off),
		.video_opts  (video_opts),
		.pal_addr    (pal_addr),
		.pal_data    (pal_data),
		.pal_we      (pal_we),
		.fb          (fb),
		.fb_pal_addr (fb_pal_addr),
		.fb_pal_data (fb_pal_data),
		.fb_pal_we   (fb_pal_we)
	);

	// ------------------------------------------------
	// Disk LEDs
	// ------------------------------------------------
	activity_led #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) hdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.req       (hdd_req),
		.led       (led_disk)
	);

	// Floppy activity shows on the user LED
	activity_led #(
		.HOLD_CYCLES (HOLD_CYCLES)
	) fdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.req       (fdd_req),
		.led       (led_user)
	);

endmodule

/* src/video_pkg.sv */
//------------------------------------------------
// Video types for the framebuffer descriptor path.
// Holds the VGA mode registers of the core, the
// descriptor handed to the scaler and the palette
// formats on both sides of the expansion.
//------------------------------------------------

package video_pkg;

	typedef logic [19:0] word_addr_t;
	typedef logic [7:0]  pal_addr_t;
	typedef logic [5:0]  chan6_t;
	typedef logic [7:0]  chan8_t;
	typedef logic [11:0] fb_dim_t;
	typedef logic [4:0]  fb_fmt_t;

	typedef enum logic [1:0] {
		depth_text  = 2'd0,
		depth_8bpp  = 2'd1,
		depth_16bpp = 2'd2,
		depth_24bpp = 2'd3
	} color_depth_t;

	// Mode registers as the VGA block of the core presents them
	typedef struct packed {
		word_addr_t   start_addr;
		logic [8:0]   width;
		logic [8:0]   stride;
		logic [10:0]  height;
		color_depth_t depth;
		logic         narrow;
		logic         line_double;
	} vga_mode_t;

	// rgb_order set means RGB, clear means BGR
	typedef struct packed {
		logic rgb_order;
		logic format_565;
	} video_opts_t;

	typedef struct packed {
		logic        en;
		logic [31:0] base;
		fb_dim_t     width;
		fb_dim_t     height;
		logic [13:0] stride;
		fb_fmt_t     format;
		logic        force_blank;
	} fb_desc_t;

	typedef struct packed {
		chan6_t r;
		chan6_t g;
		chan6_t b;
	} pal18_t;

	typedef struct packed {
		chan8_t r;
		chan8_t g;
		chan8_t b;
	} pal24_t;

	// Places the framebuffer at 3F800000 in host memory
	localparam logic [9:0] FB_BASE_PREFIX = 10'b0011_111110;

endpackage

/* verif/host_bridge_properties.sv */
//------------------------------------------------
// Concurrent checks on the host bridge outputs.
// Bound into every host_bridge instance below.
//------------------------------------------------

`timescale 1ns/1ps

module host_bridge_properties
	import video_pkg::*;
(
	input logic     clk_sys,
	input logic     cpu_reset,
	input logic     pal_we,
	input logic     fb_pal_we,
	input logic     led_disk,
	input logic     led_user,
	input fb_desc_t fb
);

	// Synchronous reset clears the LEDs and the palette strobe
	reset_clears_outputs: assert property (@(posedge clk_sys)
		cpu_reset |=> !led_disk && !led_user && !fb_pal_we)
		else $error("LED or fb_pal_we high one cycle after reset");

	pal_we_follows: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		pal_we |=> fb_pal_we)
		else $error("fb_pal_we missing one cycle after pal_we");

	pal_we_idle: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		!pal_we |=> !fb_pal_we)
		else $error("fb_pal_we without pal_we the cycle before");

	// Base sits in the framebuffer window, word aligned
	fb_base_window: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		fb.base[31:22] == FB_BASE_PREFIX && fb.base[1:0] == 2'b00)
		else $error("fb.base %h outside the framebuffer window", fb.base);

endmodule

bind host_bridge host_bridge_properties host_bridge_props (
	.clk_sys   (clk_sys),
	.cpu_reset (cpu_reset),
	.pal_we    (pal_we),
	.fb_pal_we (fb_pal_we),
	.led_disk  (led_disk),
	.led_user  (led_user),
	.fb        (fb)
);

/* verif/host_bridge_tb.sv */
//------------------------------------------------
// Testbench for the host bridge. A table of audio,
// framebuffer, palette and LED rows is applied in
// order. Each row is checked against reference
// models of the mixing, descriptor and LED rules.
//------------------------------------------------

`timescale 1ns/1ps

module host_bridge_tb
	import audio_pkg::*;
	import video_pkg::*;
();

	localparam int HOLD = 40;

	typedef enum {kind_audio, kind_fb, kind_pal, kind_led} kind_t;

	// Stimulus row whose settle gives the wait in cycles or the LED retrigger gap
	typedef struct {
		kind_t       kind;
		boost_t      boost;
		logic        spk;
		spk_vol_t    vol;
		vga_mode_t   mode;
		video_opts_t opts;
		logic        off;
		logic [7:0]  req;
		int          settle;
	} test_row_t;

	logic        clk_sys;
	logic        cpu_reset;
	sample_t     sb_left;
	sample_t     sb_right;
	logic        speaker;
	spk_vol_t    spk_vol;
	boost_t      boost;
	vga_mode_t   vga_mode;
	logic        vga_off;
	video_opts_t video_opts;
	pal_addr_t   pal_addr;
	pal18_t      pal_data;
	logic        pal_we;
	logic [7:0]  disk_req;
	sample_t     audio_left;
	sample_t     audio_right;
	fb_desc_t    fb;
	pal_addr_t   fb_pal_addr;
	pal24_t      fb_pal_data;
	logic        fb_pal_we;
	logic        led_disk;
	logic        led_user;

	test_row_t   rows[$];
	logic [31:0] lcg_state = 32'd26857;
	int          errors = 0;
	int          tests = 0;
	logic        timed_out = 1'b0;

	// Magnitudes right around both knees and full negative scale
	sample_t knee_vals [8] = '{16'sd14043, 16'sd14044, 16'sd14045, -16'sd14044,
		16'sd7398, 16'sd7399, -16'sd7400, 16'sh8000};

	host_bridge #(.HOLD_CYCLES(HOLD)) host_bridge_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	// --------------------------------------------------
	// Reference models
	// --------------------------------------------------
	// Speaker adds 2048 << step and the sum wraps at 16 bits
	function automatic sample_t ref_mix(sample_t s, logic spk, spk_vol_t vol);
		int sum;
		sum = int'(s) + (spk ? (2048 << vol) : 0);
		return sample_t'(sum[15:0]);
	endfunction

	function automatic sample_t ref_comp(sample_t x, boost_t b);
		int mag;
		int y;
		int gain;
		int knee;
		int slope;
		int offs;
		gain  = (b == boost_4x) ? 4 : 2;
		knee  = (b == boost_4x) ? 7399 : 14044;
		slope = (b == boost_4x) ? 8 : 4;
		offs  = (b == boost_4x) ? 29596 : 28088;
		mag = (x < 0) ? -int'(x) : int'(x);
		y = (mag < knee) ? mag * gain : (mag - knee) / slope + offs;
		y = (x < 0) ? -y : y;
		return sample_t'(y[15:0]);
	endfunction

	function automatic sample_t ref_audio(sample_t s, test_row_t r);
		sample_t m;
		m = ref_mix(s, r.spk, r.vol);
		return (r.boost == boost_none) ? m : ref_comp(m, r.boost);
	endfunction

	function automatic fb_desc_t ref_desc(vga_mode_t m, video_opts_t o, logic off);
		fb_desc_t d;
		d.en     = !m.narrow && (m.depth != depth_text);
		d.base   = 32'h3F80_0000 + 32'(m.start_addr) * 32'd4;
		d.width  = (m.depth == depth_24bpp) ? 12'd640 :
		           m.narrow ? 12'(m.width) * 12'd4 : 12'(m.width) * 12'd8;
		d.height = m.line_double ? 12'(m.height) / 12'd2 : 12'(m.height);
		d.stride = 14'(m.stride) * 14'd8;
		d.format[2:0] = (m.depth == depth_24bpp) ? 3'd5 :
		                (m.depth == depth_16bpp) ? 3'd4 : 3'd3;
		d.format[4] = !o.rgb_order;
		d.format[3] = !o.format_565;
		d.force_blank = off;
		return d;
	endfunction

	// Channel times 4 plus its top two bits
	function automatic pal24_t ref_pal(pal18_t p);
		pal24_t w;
		w.r = 8'(p.r) * 8'd4 + 8'(p.r / 6'd16);
		w.g = 8'(p.g) * 8'd4 + 8'(p.g / 6'd16);
		w.b = 8'(p.b) * 8'd4 + 8'(p.b / 6'd16);
		return w;
	endfunction

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_sample(string name, sample_t got, sample_t exp);
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_desc(fb_desc_t got, fb_desc_t exp);
		if (got !== exp) begin
			errors++;
			$display("** Error fb: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_pal(pal_addr_t got_a, pal24_t got_d, pal_addr_t exp_a, pal24_t exp_d);
		if (got_a !== exp_a) begin
			errors++;
			$display("** Error fb_pal_addr: got %h expected %h", got_a, exp_a);
		end
		if (got_d !== exp_d) begin
			errors++;
			$display("** Error fb_pal_data: got %h expected %h", got_d, exp_d);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Moves to the drive point 2 ns after the n-th rising edge
	task automatic advance(int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	// --------------------------------------------------
	// Table construction
	// --------------------------------------------------
	task automatic add_audio(boost_t b, logic spk, spk_vol_t vol);
		test_row_t r;
		r.kind   = kind_audio;
		r.boost  = b;
		r.spk    = spk;
		r.vol    = vol;
		r.settle = (b == boost_none) ? 1 : 2;
		rows.push_back(r);
	endtask

	task automatic add_fb(color_depth_t d, logic narrow, logic dbl, video_opts_t o, logic off);
		test_row_t r;
		r.kind                 = kind_fb;
		r.mode.start_addr      = 20'({lcg_next(), lcg_next()});
		r.mode.width           = 9'(lcg_next());
		r.mode.stride          = 9'(lcg_next());
		r.mode.height          = 11'(lcg_next());
		r.mode.depth           = d;
		r.mode.narrow          = narrow;
		r.mode.line_double     = dbl;
		r.opts                 = o;
		r.off                  = off;
		r.settle               = 1;
		rows.push_back(r);
	endtask

	task automatic add_strobe(kind_t k, logic [7:0] req, int settle);
		test_row_t r;
		r.kind   = k;
		r.req    = req;
		r.settle = settle;
		rows.push_back(r);
	endtask

	// --------------------------------------------------
	// Row execution
	// --------------------------------------------------
	task automatic run_audio(test_row_t r);
		sample_t l;
		sample_t rt;
		for (int i = 0; i < 16; i++) begin
			l  = (r.boost != boost_none && i < 8) ? knee_vals[i] : sample_t'(lcg_next());
			rt = sample_t'(lcg_next());
			sb_left  = l;
			sb_right = rt;
			speaker  = r.spk;
			spk_vol  = r.vol;
			boost    = r.boost;
			advance(r.settle);
			check_sample("audio_left", audio_left, ref_audio(l, r));
			check_sample("audio_right", audio_right, ref_audio(rt, r));
		end
	endtask

	task automatic run_fb(test_row_t r);
		vga_mode   = r.mode;
		video_opts = r.opts;
		vga_off    = r.off;
		advance(r.settle);
		check_desc(fb, ref_desc(r.mode, r.opts, r.off));
	endtask

	task automatic run_pal(test_row_t r);
		pal18_t    p;
		pal_addr_t a;
		p = 18'({lcg_next(), lcg_next()});
		a = 8'(lcg_next());
		pal_addr = a;
		pal_data = p;
		pal_we   = 1'b1;
		advance(r.settle);
		pal_we = 1'b0;
		check_bit("fb_pal_we", fb_pal_we, 1'b1);
		check_pal(fb_pal_addr, fb_pal_data, a, ref_pal(p));
		advance(1);
		check_bit("fb_pal_we", fb_pal_we, 1'b0);
	endtask

	task automatic run_led(test_row_t r);
		logic disk;
		int   lit;
		disk = |r.req[5:0];
		disk_req = r.req;
		advance(1);
		disk_req = 8'h00;
		// Second pulse part way through the hold
		if (r.settle > 0) begin
			advance(r.settle);
			disk_req = r.req;
			advance(1);
			disk_req = 8'h00;
		end
		lit = 0;
		while ((disk ? led_disk : led_user) && lit <= 2 * HOLD) begin
			check_bit(disk ? "led_user" : "led_disk", disk ? led_user : led_disk, 1'b0);
			lit++;
			advance(1);
		end
		if (lit > 2 * HOLD) begin
			timed_out = 1'b1;
			$display("Timeout: LED still lit after %0d cycles", lit);
		end else if (lit != HOLD) begin
			errors++;
			$display("** Error %s hold cycles: got %h expected %h",
				disk ? "led_disk" : "led_user", lit, HOLD);
		end
	endtask

	task automatic report_test(int idx, string what, int err_before);
		tests++;
		$display("test %0d %s: %s", idx, what,
			(errors == err_before && !timed_out) ? "ok" : "FAILED");
	endtask

	initial begin
		int err_before;
		// Inputs stay busy during reset so only cpu_reset keeps the outputs low
		cpu_reset      = 1'b1;
		sb_left        = 16'sh1234;
		sb_right       = -16'sd3000;
		speaker        = 1'b1;
		spk_vol        = 2'd3;
		boost          = boost_none;
		vga_mode       = '0;
		vga_mode.depth = depth_8bpp;
		vga_off        = 1'b0;
		video_opts     = '0;
		pal_addr       = '0;
		pal_data       = '0;
		pal_we         = 1'b1;
		disk_req       = 8'hff;

		add_audio(boost_none, 1'b0, 2'd0);
		for (int v = 0; v < 4; v++) begin
			add_audio(boost_none, 1'b1, spk_vol_t'(v));
		end
		add_audio(boost_2x, 1'b0, 2'd0);
		add_audio(boost_2x, 1'b1, 2'd1);
		add_audio(boost_4x, 1'b0, 2'd0);
		add_audio(boost_4x, 1'b1, 2'd3);
		add_fb(depth_text, 1'b0, 1'b0, 2'b00, 1'b0);
		add_fb(depth_8bpp, 1'b0, 1'b0, 2'b01, 1'b0);
		add_fb(depth_16bpp, 1'b0, 1'b1, 2'b10, 1'b0);
		add_fb(depth_24bpp, 1'b0, 1'b0, 2'b11, 1'b0);
		add_fb(depth_8bpp, 1'b1, 1'b0, 2'b11, 1'b0);
		add_fb(depth_16bpp, 1'b1, 1'b1, 2'b00, 1'b0);
		add_fb(depth_24bpp, 1'b0, 1'b1, 2'b01, 1'b1);
		add_fb(depth_24bpp, 1'b1, 1'b0, 2'b10, 1'b0);
		repeat (4) begin
			add_strobe(kind_pal, 8'h00, 1);
		end
		add_strobe(kind_led, 8'h04, 0);
		add_strobe(kind_led, 8'h80, 0);
		add_strobe(kind_led, 8'h80, 15);

		// Plain mix register under reset
		advance(15);
		check_sample("audio_left", audio_left, 16'sd0);
		check_sample("audio_right", audio_right, 16'sd0);
		boost = boost_4x;

		// Compressed register and the other outputs on the last reset cycle
		advance(1);
		check_bit("led_disk", led_disk, 1'b0);
		check_bit("led_user", led_user, 1'b0);
		check_bit("fb.en", fb.en, 1'b0);
		check_bit("fb_pal_we", fb_pal_we, 1'b0);
		check_sample("audio_left", audio_left, 16'sd0);
		check_sample("audio_right", audio_right, 16'sd0);

		sb_left   = '0;
		sb_right  = '0;
		speaker   = 1'b0;
		spk_vol   = '0;
		boost     = boost_none;
		vga_mode  = '0;
		pal_we    = 1'b0;
		disk_req  = '0;
		cpu_reset = 1'b0;
		report_test(0, "reset", 0);

		for (int i = 0; i < rows.size(); i++) begin
			err_before = errors;
			case (rows[i].kind)
				kind_audio: run_audio(rows[i]);
				kind_fb:    run_fb(rows[i]);
				kind_pal:   run_pal(rows[i]);
				default:    run_led(rows[i]);
			endcase
			report_test(i + 1, rows[i].kind.name(), err_before);
			if (timed_out) begin
				break;
			end
		end

		$display("%0d tests run, %0d errors, timeout %0d", tests, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
